//--- cache_core.sv
`timescale 1ns/1ps
`default_nettype none

module cache_core (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             req_valid,
    input  wire logic             req_write,
    input  wire cache_pkg::addr_t req_addr,
    input  wire cache_pkg::word_t req_wdata,
    input  wire cache_pkg::strb_t req_strb,
    output logic                  req_ready,
    output logic                  resp_valid,
    output cache_pkg::word_t      resp_rdata,
    output logic                  mem_valid,
    output logic                  mem_write,
    output cache_pkg::addr_t      mem_addr,
    output cache_pkg::word_t      mem_wdata,
    input  wire logic             mem_ready,
    input  wire cache_pkg::word_t mem_rdata
);
    import cache_pkg::*;

    // Lookup to engines
    logic      refill_start, refill_done, evict_start, wb_busy;
    addr_t     refill_base, evict_base;
    line_t     fill_line, evict_line;

    // Lookup to line store
    logic      rd_en, wr_en, wr_fill;
    way_idx_t  rd_way, wr_way;
    set_idx_t  rd_set, wr_set;
    word_idx_t store_word_idx;
    word_t     store_data;
    strb_t     store_strb;
    line_t     rd_line;

    // Engines to arbiter
    logic      rf_valid, rf_ready, wb_valid, wb_ready;
    addr_t     rf_addr, wb_addr;
    word_t     rf_rdata, wb_wdata;

    cache_lookup u_lookup (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_strb,
        .req_ready, .resp_valid,
        .refill_start, .refill_base, .refill_done, .fill_line,
        .evict_start, .evict_base, .evict_line, .wb_busy,
        .rd_en, .rd_way, .rd_set, .rd_line,
        .wr_en, .wr_way, .wr_set, .wr_fill,
        .store_word_idx, .store_data, .store_strb
    );

    line_store u_line_store (
        .clk,
        .rd_en, .rd_way, .rd_set,
        .wr_en, .wr_way, .wr_set, .wr_fill, .fill_line,
        .store_word_idx, .store_data, .store_strb,
        .rd_line, .load_word(resp_rdata)
    );

    refill_engine u_refill (
        .clk, .rst,
        .refill_start, .refill_base,
        .rf_valid, .rf_addr, .rf_ready, .rf_rdata,
        .refill_done, .fill_line
    );

    writeback_engine u_writeback (
        .clk, .rst,
        .evict_start, .evict_base, .evict_line,
        .wb_valid, .wb_addr, .wb_wdata, .wb_ready,
        .wb_busy
    );

    mem_arbiter u_arbiter (
        .clk, .rst,
        .rf_valid, .rf_addr, .rf_ready, .rf_rdata,
        .wb_valid, .wb_addr, .wb_wdata, .wb_ready,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata, .mem_ready, .mem_rdata
    );

endmodule

`default_nettype wire

//--- cache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lookup (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   req_valid,
    input  wire logic                   req_write,
    input  wire cache_pkg::addr_t       req_addr,
    input  wire cache_pkg::word_t       req_wdata,
    input  wire cache_pkg::strb_t       req_strb,
    output logic                        req_ready,
    output logic                        resp_valid,
    output logic                        refill_start,
    output cache_pkg::addr_t            refill_base,
    input  wire logic                   refill_done,
    input  wire cache_pkg::line_t       fill_line,
    output logic                        evict_start,
    output cache_pkg::addr_t            evict_base,
    output cache_pkg::line_t            evict_line,
    input  wire logic                   wb_busy,
    output logic                        rd_en,
    output cache_pkg::way_idx_t         rd_way,
    output cache_pkg::set_idx_t         rd_set,
    input  wire cache_pkg::line_t       rd_line,
    output logic                        wr_en,
    output cache_pkg::way_idx_t         wr_way,
    output cache_pkg::set_idx_t         wr_set,
    output logic                        wr_fill,
    output cache_pkg::word_idx_t        store_word_idx,
    output cache_pkg::word_t            store_data,
    output cache_pkg::strb_t            store_strb
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        ST_READY,
        ST_STORE,
        ST_WAIT_WB,
        ST_REFILL,
        ST_INSTALL,
        ST_REPLAY
    } lookup_state_t;

    lookup_state_t state_q;

    tag_t                tag_q   [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
    way_idx_t            victim_q;

    // Held request
    addr_t    addr_q;
    word_t    wdata_q;
    strb_t    strb_q;
    logic     write_q;
    way_idx_t way_q;

    addr_t    lk_addr;
    set_idx_t lk_set, set_q;
    logic     hit, accept, victim_dirty;
    way_idx_t hit_way;

    // A replay repeats the lookup with the held address
    assign lk_addr = (state_q == ST_REPLAY) ? addr_q : req_addr;
    assign lk_set  = lk_addr[OFFSET_BITS +: SET_BITS];
    assign set_q   = addr_q[OFFSET_BITS +: SET_BITS];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[w][lk_set] && tag_q[w][lk_set] == lk_addr[ADDR_BITS-1 -: TAG_BITS]) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign req_ready = (state_q == ST_READY);
    assign accept    = req_valid && req_ready;

    // On a miss the victim line is read so it can go to the writeback buffer
    assign rd_en  = accept || (state_q == ST_REPLAY);
    assign rd_way = hit ? hit_way : victim_q;
    assign rd_set = lk_set;

    assign victim_dirty = valid_q[victim_q][set_q] && dirty_q[victim_q][set_q];
    assign refill_start = (state_q == ST_WAIT_WB) && !wb_busy;
    assign evict_start  = refill_start && victim_dirty;
    assign refill_base  = {addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign evict_base   = {tag_q[victim_q][set_q], set_q, {OFFSET_BITS{1'b0}}};
    assign evict_line   = rd_line;

    assign wr_en          = (state_q == ST_STORE) || (state_q == ST_INSTALL);
    assign wr_fill        = (state_q == ST_INSTALL);
    assign wr_way         = wr_fill ? victim_q : way_q;
    assign wr_set         = set_q;
    assign store_word_idx = addr_q[2 +: WORD_IDX_BITS];
    assign store_data     = wdata_q;
    assign store_strb     = strb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_READY;
            resp_valid <= 1'b0;
            victim_q   <= '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            resp_valid <= (accept && hit) || (state_q == ST_REPLAY);
            case (state_q)
                ST_READY: begin
                    if (accept) begin
                        if (!hit)
                            state_q <= ST_WAIT_WB;
                        else if (req_write)
                            state_q <= ST_STORE;
                    end
                end
                ST_STORE: begin
                    dirty_q[way_q][set_q] <= 1'b1;
                    state_q <= ST_READY;
                end
                ST_WAIT_WB: begin
                    // Old victim must reach memory before the next refill reads it
                    if (!wb_busy)
                        state_q <= ST_REFILL;
                end
                ST_REFILL: begin
                    if (refill_done)
                        state_q <= ST_INSTALL;
                end
                ST_INSTALL: begin
                    tag_q[victim_q][set_q]   <= addr_q[ADDR_BITS-1 -: TAG_BITS];
                    valid_q[victim_q][set_q] <= 1'b1;
                    dirty_q[victim_q][set_q] <= write_q;
                    victim_q <= victim_q + 1'b1;
                    state_q  <= ST_REPLAY;
                end
                ST_REPLAY: begin
                    state_q <= write_q ? ST_STORE : ST_READY;
                end
                default: state_q <= ST_READY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            strb_q  <= req_strb;
            write_q <= req_write;
        end
        if (rd_en)
            way_q <= hit_way;
    end

    // Processor stays stalled while the refilled line arrives
    assert property (@(posedge clk) disable iff (rst) refill_done |-> !req_ready)
        else $error("req_ready high at refill_done");

    // Writeback engine is idle at refill start and only a dirty victim makes it busy
    assert property (@(posedge clk) disable iff (rst)
        refill_start |=> (wb_busy == $past(evict_start)))
        else $error("wb_busy does not follow evict_start at refill start");

endmodule

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Cache geometry
    localparam int LINE_WORDS = 4;
    localparam int NUM_SETS   = 8;
    localparam int NUM_WAYS   = 2;
    localparam int ADDR_BITS  = 32;

    // Address field widths
    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);
    localparam int SET_BITS      = $clog2(NUM_SETS);
    localparam int WAY_BITS      = $clog2(NUM_WAYS);
    localparam int OFFSET_BITS   = WORD_IDX_BITS + 2;
    localparam int TAG_BITS      = ADDR_BITS - SET_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]       addr_t;
    typedef logic [31:0]                word_t;
    typedef logic [3:0]                 strb_t;
    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [SET_BITS-1:0]        set_idx_t;
    typedef logic [WAY_BITS-1:0]        way_idx_t;
    typedef logic [WORD_IDX_BITS-1:0]   word_idx_t;

    // Word 0 sits in the low 32 bits of a line
    typedef logic [LINE_WORDS*32-1:0]   line_t;

endpackage

`default_nettype wire

//--- line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  wire logic                   clk,
    input  wire logic                   rd_en,
    input  wire cache_pkg::way_idx_t    rd_way,
    input  wire cache_pkg::set_idx_t    rd_set,
    input  wire logic                   wr_en,
    input  wire cache_pkg::way_idx_t    wr_way,
    input  wire cache_pkg::set_idx_t    wr_set,
    input  wire logic                   wr_fill,
    input  wire cache_pkg::line_t       fill_line,
    input  wire cache_pkg::word_idx_t   store_word_idx,
    input  wire cache_pkg::word_t       store_data,
    input  wire cache_pkg::strb_t       store_strb,
    output cache_pkg::line_t            rd_line,
    output cache_pkg::word_t            load_word
);
    import cache_pkg::*;

    line_t data_q [NUM_WAYS][NUM_SETS];

    word_t old_word;
    word_t new_word;
    line_t merged_line;

    // Word addressed by the held request, taken from the last read
    assign old_word  = rd_line[32*store_word_idx +: 32];
    assign load_word = old_word;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            new_word[8*b +: 8] = store_strb[b] ? store_data[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    always_comb begin
        merged_line = rd_line;
        merged_line[32*store_word_idx +: 32] = new_word;
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            data_q[wr_way][wr_set] <= wr_fill ? fill_line : merged_line;
        if (rd_en)
            rd_line <= data_q[rd_way][rd_set];
    end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               rf_valid,
    input  wire cache_pkg::addr_t   rf_addr,
    output logic                    rf_ready,
    output cache_pkg::word_t        rf_rdata,
    input  wire logic               wb_valid,
    input  wire cache_pkg::addr_t   wb_addr,
    input  wire cache_pkg::word_t   wb_wdata,
    output logic                    wb_ready,
    output logic                    mem_valid,
    output logic                    mem_write,
    output cache_pkg::addr_t        mem_addr,
    output cache_pkg::word_t        mem_wdata,
    input  wire logic               mem_ready,
    input  wire cache_pkg::word_t   mem_rdata
);
    logic prio_wb_q;
    logic lock_q;
    logic lock_wb_q;
    logic gnt_wb;

    // A stalled beat keeps its owner, otherwise the priority bit decides
    assign gnt_wb = lock_q ? lock_wb_q : (wb_valid && (!rf_valid || prio_wb_q));

    assign mem_valid = gnt_wb ? wb_valid : rf_valid;
    assign mem_write = gnt_wb;
    assign mem_addr  = gnt_wb ? wb_addr : rf_addr;
    assign mem_wdata = wb_wdata;

    assign rf_ready = !gnt_wb && rf_valid && mem_ready;
    assign wb_ready = gnt_wb && wb_valid && mem_ready;
    assign rf_rdata = mem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_wb_q <= 1'b0;
            lock_q    <= 1'b0;
            lock_wb_q <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            // Other engine goes first after a completed beat
            prio_wb_q <= !gnt_wb;
            lock_q    <= 1'b0;
        end else if (mem_valid) begin
            lock_q    <= 1'b1;
            lock_wb_q <= gnt_wb;
        end
    end

    // Stalled beat holds its address, direction and write data
    assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_write)
            && (!mem_write || $stable(mem_wdata)))
        else $error("memory request changed while stalled");

endmodule

`default_nettype wire

//--- refill_engine.sv
`timescale 1ns/1ps
`default_nettype none

module refill_engine (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               refill_start,
    input  wire cache_pkg::addr_t   refill_base,
    output logic                    rf_valid,
    output cache_pkg::addr_t        rf_addr,
    input  wire logic               rf_ready,
    input  wire cache_pkg::word_t   rf_rdata,
    output logic                    refill_done,
    output cache_pkg::line_t        fill_line
);
    import cache_pkg::*;

    logic      busy_q;
    word_idx_t idx_q;
    addr_t     base_q;
    logic      last_beat;

    assign last_beat = rf_ready && (idx_q == word_idx_t'(LINE_WORDS - 1));

    assign rf_valid = busy_q;
    assign rf_addr  = {base_q[ADDR_BITS-1:OFFSET_BITS], idx_q, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            idx_q       <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= last_beat;
            if (refill_start) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
            end else if (rf_ready) begin
                idx_q <= idx_q + 1'b1;
                if (last_beat)
                    busy_q <= 1'b0;
            end
        end
    end

    // Fill buffer collects beats in address order
    always_ff @(posedge clk) begin
        if (refill_start)
            base_q <= refill_base;
        if (rf_ready)
            fill_line[32*idx_q +: 32] <= rf_rdata;
    end

    assert property (@(posedge clk) disable iff (rst) refill_start |-> !busy_q)
        else $error("refill_start while refill busy");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_core -f sim.f \
    && ./obj_dir/Vtb_cache_core | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim.f
cache_pkg.sv
mem_arbiter.sv
refill_engine.sv
writeback_engine.sv
line_store.sv
cache_lookup.sv
cache_core.sv
tb_cache_core.sv

//--- tb_cache_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_core;
    import cache_pkg::*;

    localparam int MEM_WORDS  = 1024;
    localparam int WAIT_LIMIT = 2000;

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_strb;
    logic  req_ready;
    logic  resp_valid;
    word_t resp_rdata;
    logic  mem_valid;
    logic  mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_ready;
    word_t mem_rdata;

    word_t       mem_words [MEM_WORDS];
    logic [7:0]  shadow [MEM_WORDS*4];
    logic [31:0] stim_state;
    logic [31:0] stall_state;
    logic        req_hit;
    int          cycle_count = 0;
    int          wb_beats = 0;

    // Accepted requests wait here in order for their response
    logic  pend_write [$];
    addr_t pend_addr [$];
    word_t pend_wdata [$];
    strb_t pend_strb [$];
    logic  pend_hit [$];
    int    pend_cycle [$];

    cache_core u_dut (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_strb,
        .req_ready, .resp_valid, .resp_rdata,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata, .mem_ready, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t next_stim();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    // Initial memory contents mix every bit of the byte address
    function automatic word_t mem_init(input addr_t a);
        return (a * 32'h9E3779B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5AC3C3;
    endfunction

    function automatic word_t expected_load(input addr_t a);
        int base;
        base = int'(a[11:2]) * 4;
        return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
    endfunction

    task automatic apply_store(input addr_t a, input word_t d, input strb_t s);
        int base;
        base = int'(a[11:2]) * 4;
        for (int b = 0; b < 4; b++) begin
            if (s[b])
                shadow[base+b] = d[8*b +: 8];
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Holds one request on the port until the DUT accepts it
    task automatic issue(input logic wr, input addr_t a, input word_t d, input strb_t s,
                         input logic hit);
        int   waited;
        logic ready_seen;
        req_valid  = 1'b1;
        req_write  = wr;
        req_addr   = a;
        req_wdata  = d;
        req_strb   = s;
        req_hit    = hit;
        waited     = 0;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            @(negedge clk);
            ready_seen = req_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!ready_seen && waited > WAIT_LIMIT)
                report_failure("request was never accepted, req_ready stayed low");
        end
        req_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pend_addr.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("accepted requests never got their responses");
        end
    endtask

    task automatic check_response();
        logic  wr;
        logic  hit;
        addr_t a;
        word_t d;
        strb_t s;
        int    acc;
        assert (pend_addr.size() != 0)
            else report_failure("resp_valid arrived with no request pending");
        wr  = pend_write.pop_front();
        a   = pend_addr.pop_front();
        d   = pend_wdata.pop_front();
        s   = pend_strb.pop_front();
        hit = pend_hit.pop_front();
        acc = pend_cycle.pop_front();
        if (hit) begin
            assert (cycle_count == acc + 1)
                else report_failure($sformatf("MISMATCH at %0t: hit answered %0d cycles late",
                                              $time, cycle_count - acc));
        end
        if (wr)
            apply_store(a, d, s);
        else
            assert (resp_rdata == expected_load(a))
                else report_failure($sformatf("MISMATCH at %0t: load %h got %h, expected %h",
                                              $time, a, resp_rdata, expected_load(a)));
    endtask

    // Memory model and response checking on every rising edge
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (!rst) begin
            if (mem_valid && mem_ready && mem_write) begin
                assert (mem_addr[31:12] == '0)
                    else report_failure("write beat outside the memory model");
                assert (mem_wdata == expected_load(mem_addr))
                    else report_failure($sformatf("MISMATCH at %0t: write beat %h is %h, expected %h",
                                                  $time, mem_addr, mem_wdata,
                                                  expected_load(mem_addr)));
                mem_words[mem_addr[11:2]] = mem_wdata;
                wb_beats++;
            end
            if (resp_valid)
                check_response();
            if (req_valid && req_ready) begin
                pend_write.push_back(req_write);
                pend_addr.push_back(req_addr);
                pend_wdata.push_back(req_wdata);
                pend_strb.push_back(req_strb);
                pend_hit.push_back(req_hit);
                pend_cycle.push_back(cycle_count);
            end
        end
    end

    // Reads answer in the handshake cycle
    assign mem_rdata = mem_words[mem_addr[11:2]];

    // About one stalled memory cycle in four
    initial begin
        mem_ready   = 1'b1;
        stall_state = 32'd74808 ^ 32'h2545F491;
        forever begin
            @(posedge clk);
            #1;
            stall_state = lcg_next(stall_state);
            mem_ready   = (stall_state[31:30] != 2'b00);
        end
    end

    initial begin
        word_t r;
        word_t d;
        addr_t a;
        int    base_beats;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_strb   = '0;
        req_hit    = 1'b0;
        stim_state = 32'd74808;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = mem_init(addr_t'(i * 4));
            for (int b = 0; b < 4; b++)
                shadow[i*4+b] = mem_words[i][8*b +: 8];
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (req_ready && !resp_valid && !mem_valid)
            else report_failure("DUT outputs are not idle after reset");

        // One untouched line per set needs a refill from memory
        for (int i = 0; i < NUM_SETS; i++)
            issue(1'b0, addr_t'(i * 16 + (i % 4) * 4), '0, '0, 1'b0);
        drain();

        // Same addresses again must hit
        for (int i = 0; i < NUM_SETS; i++)
            issue(1'b0, addr_t'(i * 16 + (i % 4) * 4), '0, '0, 1'b1);
        drain();

        // Each strobed store into a resident line is read back
        for (int i = 0; i < NUM_SETS; i++) begin
            r = next_stim();
            d = next_stim();
            a = addr_t'(i * 16 + int'(r[29:28]) * 4);
            issue(1'b1, a, d, strb_t'(r[27:24]), 1'b1);
            issue(1'b0, a, '0, '0, 1'b1);
        end
        drain();

        // Five lines into set 5 overflow its ways and force dirty evictions
        base_beats = wb_beats;
        for (int t = 1; t <= 5; t++) begin
            r = next_stim();
            d = next_stim();
            issue(1'b1, addr_t'(t * 128 + 5 * 16 + int'(r[29:28]) * 4), d, 4'hF, 1'b0);
        end
        for (int t = 0; t <= 5; t++) begin
            for (int w = 0; w < LINE_WORDS; w++)
                issue(1'b0, addr_t'(t * 128 + 5 * 16 + w * 4), '0, '0, 1'b0);
        end
        drain();
        assert (wb_beats > base_beats)
            else report_failure("no dirty line was written back to memory");

        // Mixed traffic over 1 KB with random gaps
        for (int n = 0; n < 300; n++) begin
            r = next_stim();
            d = next_stim();
            issue(r[31], addr_t'({r[23:16], 2'b00}), d, strb_t'(r[27:24]), 1'b0);
            if (r[15:14] == 2'b00)
                idle(int'(r[13:12]) + 1);
        end
        drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- writeback_engine.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_engine (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               evict_start,
    input  wire cache_pkg::addr_t   evict_base,
    input  wire cache_pkg::line_t   evict_line,
    output logic                    wb_valid,
    output cache_pkg::addr_t        wb_addr,
    output cache_pkg::word_t        wb_wdata,
    input  wire logic               wb_ready,
    output logic                    wb_busy
);
    import cache_pkg::*;

    logic      busy_q;
    word_idx_t idx_q;
    addr_t     base_q;
    line_t     line_q;

    assign wb_valid = busy_q;
    assign wb_busy  = busy_q;
    assign wb_addr  = {base_q[ADDR_BITS-1:OFFSET_BITS], idx_q, 2'b00};
    assign wb_wdata = line_q[32*idx_q +: 32];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (evict_start) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (wb_ready) begin
            idx_q <= idx_q + 1'b1;
            // Busy drops with the last completed beat
            if (idx_q == word_idx_t'(LINE_WORDS - 1))
                busy_q <= 1'b0;
        end
    end

    // Victim copy, so the line store slot can be refilled at once
    always_ff @(posedge clk) begin
        if (evict_start) begin
            base_q <= evict_base;
            line_q <= evict_line;
        end
    end

endmodule

`default_nettype wire
